/* rtl/sap_pkg.sv */
package sap_pkg;

    // Widths
    typedef logic [7:0] data_t;    // A, B, memory word, output word
    typedef logic [3:0] addr_t;    // PC and MAR
    typedef logic [3:0] opcode_t;  // Upper nibble of an instruction
    typedef logic [1:0] a_src_t;   // Accumulator load source select

    localparam int MEM_DEPTH = 16; // Fixed by the 4-bit address

    // Instruction set
    localparam opcode_t OP_NOP = 4'h0;
    localparam opcode_t OP_LDA = 4'h1;
    localparam opcode_t OP_ADD = 4'h2;
    localparam opcode_t OP_SUB = 4'h3;
    localparam opcode_t OP_STA = 4'h4;
    localparam opcode_t OP_LDI = 4'h5;
    localparam opcode_t OP_JMP = 4'h6;
    localparam opcode_t OP_JC  = 4'h7;  // Jump if carry
    localparam opcode_t OP_JZ  = 4'h8;  // Jump if zero
    localparam opcode_t OP_OUT = 4'hE;
    localparam opcode_t OP_HLT = 4'hF;

    // MAR source select
    localparam logic MAR_SRC_PC   = 1'b0;
    localparam logic MAR_SRC_OPND = 1'b1;  // Operand nibble of the IR

    // Accumulator source select
    localparam a_src_t A_SRC_MEM = 2'd0;
    localparam a_src_t A_SRC_IMM = 2'd1;  // Zero-extended immediate
    localparam a_src_t A_SRC_ALU = 2'd2;

    // Micro-step sequencer
    typedef enum logic [2:0] {
        S_IDLE,         // Program port owns memory
        S_FETCH_ADDR,   // MAR <- PC, read issued
        S_FETCH_INSTR,  // IR <- mem, PC + 1
        S_DECODE,
        S_MEM,          // Operand access
        S_ALU,
        S_OUT_WAIT,     // Waiting for the out transfer
        S_HALT
    } seq_state_t;

endpackage

/* rtl/sap_ctrl_if.sv */
`timescale 1ns/10ps

// Micro-operation controls, one set per sequencer step
interface sap_ctrl_if;
    import sap_pkg::*;

    logic   mar_load;
    logic   mar_src;     // MAR_SRC_PC or MAR_SRC_OPND
    logic   mem_read;
    logic   mem_write;   // Store A at MAR
    logic   a_load;
    a_src_t a_src;
    logic   b_load;
    logic   alu_sub;     // 0 add, 1 subtract
    logic   flags_load;
    logic   out_load;
    addr_t  operand;     // Low nibble of the IR
    addr_t  pc;          // Fetch address for the MAR

    modport ctrl (output mar_load, mar_src, mem_read, mem_write, a_load, a_src, b_load,
                  alu_sub, flags_load, out_load, operand, pc);
    modport dp   (input a_load, a_src, b_load, alu_sub, flags_load, out_load, operand);
    modport mem  (input mar_load, mar_src, mem_read, mem_write, operand, pc);

endinterface

/* rtl/sap_decode.sv */
`timescale 1ns/10ps

module sap_decode (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           run,
    input  sap_pkg::data_t rdata,     // Instruction byte from memory
    input  logic           cf,
    input  logic           zf,
    input  logic           out_done,  // Out port transfer this cycle
    sap_ctrl_if.ctrl       ctrl,
    output logic           idle,
    output logic           halted
);
    import sap_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    addr_t      pc;
    data_t      ir;
    opcode_t    op;
    logic       take_jump;

    assign op        = ir[7:4];
    assign take_jump = (op == OP_JMP) || (op == OP_JC && cf) || (op == OP_JZ && zf);

    assign idle   = (state == S_IDLE);
    assign halted = (state == S_HALT);

    assign ctrl.operand = ir[3:0];
    assign ctrl.pc      = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            pc    <= '0;
            ir    <= '0;
        end else if (!run) begin
            state <= S_IDLE;  // Run low aborts from any step
            pc    <= '0;
        end else begin
            state <= state_nxt;
            if (state == S_FETCH_INSTR) begin
                ir <= rdata;       // Read was issued with the MAR load
                pc <= pc + 1'b1;   // Wraps at 16
            end else if (state == S_DECODE && take_jump) begin
                pc <= ir[3:0];
            end
        end
    end

    // Next step and the controls for the current one
    always_comb begin
        state_nxt       = state;
        ctrl.mar_load   = 1'b0;
        ctrl.mar_src    = MAR_SRC_PC;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.a_load     = 1'b0;
        ctrl.a_src      = A_SRC_MEM;
        ctrl.b_load     = 1'b0;
        ctrl.alu_sub    = 1'b0;
        ctrl.flags_load = 1'b0;
        ctrl.out_load   = 1'b0;
        case (state)
            S_IDLE:        state_nxt = S_FETCH_ADDR;  // Taken only with run high
            S_FETCH_ADDR: begin
                ctrl.mar_load = 1'b1;
                ctrl.mem_read = 1'b1;
                state_nxt     = S_FETCH_INSTR;
            end
            S_FETCH_INSTR: state_nxt = S_DECODE;
            S_DECODE: begin
                state_nxt = S_FETCH_ADDR;  // NOP and jumps end here
                case (op)
                    OP_LDA, OP_ADD, OP_SUB: begin
                        ctrl.mar_load = 1'b1;
                        ctrl.mar_src  = MAR_SRC_OPND;
                        ctrl.mem_read = 1'b1;  // Operand ready in S_MEM
                        state_nxt     = S_MEM;
                    end
                    OP_STA: begin
                        ctrl.mar_load = 1'b1;
                        ctrl.mar_src  = MAR_SRC_OPND;
                        state_nxt     = S_MEM;
                    end
                    OP_LDI: begin
                        ctrl.a_load = 1'b1;
                        ctrl.a_src  = A_SRC_IMM;
                    end
                    OP_OUT: begin
                        ctrl.out_load = 1'b1;
                        state_nxt     = S_OUT_WAIT;
                    end
                    OP_HLT:  state_nxt = S_HALT;
                    default: state_nxt = S_FETCH_ADDR;
                endcase
            end
            S_MEM: begin
                state_nxt = S_FETCH_ADDR;
                case (op)
                    OP_LDA: ctrl.a_load = 1'b1;  // A <- memory data
                    OP_ADD, OP_SUB: begin
                        ctrl.b_load = 1'b1;
                        state_nxt   = S_ALU;
                    end
                    default: ctrl.mem_write = 1'b1;  // STA
                endcase
            end
            S_ALU: begin
                ctrl.a_load     = 1'b1;
                ctrl.a_src      = A_SRC_ALU;
                ctrl.alu_sub    = (op == OP_SUB);
                ctrl.flags_load = 1'b1;
                state_nxt       = S_FETCH_ADDR;
            end
            S_OUT_WAIT: if (out_done) state_nxt = S_FETCH_ADDR;
            S_HALT:     state_nxt = S_HALT;  // Left only by run low
            default:    state_nxt = S_IDLE;
        endcase
    end

endmodule

/* rtl/sap_execute.sv */
`timescale 1ns/10ps

module sap_execute (
    input  logic           clk,
    input  logic           arst_n,
    sap_ctrl_if.dp         ctrl,
    input  sap_pkg::data_t rdata,  // Memory read data
    output sap_pkg::data_t acc,
    output logic           cf,
    output logic           zf
);
    import sap_pkg::*;

    data_t      b_reg;
    data_t      b_opnd;   // B or its complement
    logic [8:0] alu_sum;  // Bit 8 is the carry out
    data_t      a_nxt;

    // Subtract as A + ~B + 1
    assign b_opnd  = ctrl.alu_sub ? ~b_reg : b_reg;
    assign alu_sum = {1'b0, acc} + {1'b0, b_opnd} + {8'd0, ctrl.alu_sub};

    always_comb begin
        case (ctrl.a_src)
            A_SRC_MEM: a_nxt = rdata;
            A_SRC_IMM: a_nxt = {4'd0, ctrl.operand};
            default:   a_nxt = alu_sum[7:0];
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc   <= '0;
            b_reg <= '0;
            cf    <= 1'b0;
            zf    <= 1'b0;
        end else begin
            if (ctrl.a_load) acc <= a_nxt;
            if (ctrl.b_load) b_reg <= rdata;
            if (ctrl.flags_load) begin  // ADD and SUB only
                cf <= alu_sum[8];       // For SUB, 1 means A >= B
                zf <= (alu_sum[7:0] == 8'd0);
            end
        end
    end

endmodule

/* rtl/sap_memory.sv */
`timescale 1ns/10ps

module sap_memory (
    input  logic           clk,
    input  logic           arst_n,
    sap_ctrl_if.mem        ctrl,
    input  logic           idle,        // Sequencer in S_IDLE
    input  sap_pkg::data_t acc,         // Store data for STA
    input  logic           prog_valid,
    input  sap_pkg::addr_t prog_addr,
    input  sap_pkg::data_t prog_data,
    output logic           prog_ready,
    output sap_pkg::data_t rdata
);
    import sap_pkg::*;

    data_t mem_q [MEM_DEPTH];  // Program and data share the array
    addr_t mar;
    addr_t mar_nxt;
    addr_t rd_addr;

    assign mar_nxt    = (ctrl.mar_src == MAR_SRC_OPND) ? ctrl.operand : ctrl.pc;
    assign rd_addr    = ctrl.mar_load ? mar_nxt : mar;  // Read alongside the MAR load
    assign prog_ready = idle;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar   <= '0;
            rdata <= '0;
        end else begin
            if (ctrl.mar_load) mar <= mar_nxt;
            if (ctrl.mem_read) rdata <= mem_q[rd_addr];
        end
    end

    // Program port only while idle, STA only while running
    always_ff @(posedge clk) begin
        if (prog_valid && prog_ready) begin
            mem_q[prog_addr] <= prog_data;
        end else if (ctrl.mem_write) begin
            mem_q[mar] <= acc;
        end
    end

endmodule

/* rtl/sap_result.sv */
`timescale 1ns/10ps

module sap_result (
    input  logic           clk,
    input  logic           arst_n,
    sap_ctrl_if.dp         ctrl,
    input  sap_pkg::data_t acc,
    input  logic           out_ready,
    output logic           out_valid,
    output sap_pkg::data_t out_data,
    output logic           out_done   // One cycle per transfer
);

    assign out_done = out_valid && out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (ctrl.out_load) begin
            out_valid <= 1'b1;
        end else if (out_done) begin
            out_valid <= 1'b0;  // Word taken
        end
    end

    // Held stable until the transfer while decode waits in S_OUT_WAIT
    always_ff @(posedge clk) begin
        if (ctrl.out_load) out_data <= acc;
    end

endmodule

/* rtl/sap_cpu_top.sv */
`timescale 1ns/10ps

module sap_cpu_top (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           run,         // Low holds the core idle at PC 0
    input  logic           prog_valid,
    input  sap_pkg::addr_t prog_addr,
    input  sap_pkg::data_t prog_data,
    output logic           prog_ready,
    output logic           out_valid,
    output sap_pkg::data_t out_data,
    input  logic           out_ready,
    output logic           halted
);
    import sap_pkg::*;

    data_t rdata;     // Memory read data to IR and datapath
    data_t acc;
    logic  cf;
    logic  zf;
    logic  out_done;
    logic  idle;

    sap_ctrl_if ctrl_if ();

    sap_decode decode_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .run      (run),
        .rdata    (rdata),
        .cf       (cf),
        .zf       (zf),
        .out_done (out_done),
        .ctrl     (ctrl_if.ctrl),
        .idle     (idle),
        .halted   (halted)
    );

    sap_execute execute_i (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl_if.dp),
        .rdata  (rdata),
        .acc    (acc),
        .cf     (cf),
        .zf     (zf)
    );

    sap_memory memory_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl_if.mem),
        .idle       (idle),
        .acc        (acc),
        .prog_valid (prog_valid),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_ready (prog_ready),
        .rdata      (rdata)
    );

    sap_result result_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl_if.dp),
        .acc       (acc),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_done  (out_done)
    );

endmodule

/* verif/sap_assertions.sv */
`timescale 1ns/10ps

module sap_assertions (
    input logic           clk,
    input logic           arst_n,
    input logic           run,
    input logic           prog_ready,
    input logic           out_valid,
    input logic           out_ready,
    input sap_pkg::data_t out_data,
    input logic           halted
);
    int fail_count = 0;

    // Word held until taken
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            $error("out port word changed or dropped before its transfer");
            fail_count++;
        end

    // Sequencer leaves S_IDLE one edge after run rises
    prog_closed: assert property (@(posedge clk) disable iff (!arst_n)
        run && $past(run) |-> !prog_ready)
        else begin
            $error("program port ready while the core runs");
            fail_count++;
        end

    halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !out_valid)
        else begin
            $error("out_valid high while halted");
            fail_count++;
        end

endmodule

bind sap_cpu_top sap_assertions assertions_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .prog_ready (prog_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .halted     (halted)
);

/* verif/sap_checker.sv */
`timescale 1ns/10ps

module sap_checker (
    input logic           clk,
    input logic           arst_n,
    input logic           run,
    input logic           prog_valid,
    input logic           prog_ready,
    input sap_pkg::addr_t prog_addr,
    input sap_pkg::data_t prog_data,
    input logic           out_valid,
    input logic           out_ready,
    input sap_pkg::data_t out_data,
    input logic           halted,
    input int             test_id
);
    import sap_pkg::*;

    localparam int STEP_LIMIT = 256;  // Far above any test program

    data_t mem_mirror [MEM_DEPTH];  // Follows prog port writes
    data_t exp_q [$];
    data_t exp_word;
    data_t model_a;                 // A and flags survive run low
    logic  model_cf;
    logic  model_zf;
    bit    exp_halt;
    logic  run_q;
    logic  halted_q;
    int    errors = 0;

    function automatic string test_label(input int id);
        case (id)
            1:       return "arithmetic";
            2:       return "memory store";
            3:       return "flags and jumps";
            4:       return "back-pressure";
            5:       return "halt and restart";
            default: return "setup";
        endcase
    endfunction

    // Instruction level model that fills exp_q and returns 1 on HLT
    function automatic bit reference_run();
        data_t      m [MEM_DEPTH];
        addr_t      pc;
        opcode_t    op;
        addr_t      arg;
        logic [8:0] sum;
        m  = mem_mirror;
        pc = '0;
        exp_q.delete();
        for (int step = 0; step < STEP_LIMIT; step++) begin
            op  = m[pc][7:4];
            arg = m[pc][3:0];
            pc  = pc + 1'b1;
            case (op)
                OP_LDA: model_a = m[arg];
                OP_ADD: begin
                    sum      = {1'b0, model_a} + {1'b0, m[arg]};
                    model_a  = sum[7:0];
                    model_cf = sum[8];
                    model_zf = (sum[7:0] == 8'd0);
                end
                OP_SUB: begin
                    model_cf = (model_a >= m[arg]);  // No borrow
                    model_a  = model_a - m[arg];     // Wraps modulo 256
                    model_zf = (model_a == 8'd0);
                end
                OP_STA: m[arg] = model_a;
                OP_LDI: model_a = {4'd0, arg};
                OP_JMP: pc = arg;
                OP_JC:  if (model_cf) pc = arg;
                OP_JZ:  if (model_zf) pc = arg;
                OP_OUT: exp_q.push_back(model_a);
                OP_HLT: return 1'b1;
                default: ;  // NOP and unused opcodes
            endcase
        end
        return 1'b0;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_a  = '0;
            model_cf = 1'b0;
            model_zf = 1'b0;
            exp_halt = 1'b0;
            run_q    = 1'b0;
            halted_q = 1'b0;
            exp_q.delete();
        end else begin
            if (prog_valid && prog_ready) mem_mirror[prog_addr] = prog_data;
            if (run && !run_q) exp_halt = reference_run();  // New run starts at address 0
            if (!run && run_q && (halted !== exp_halt)) begin
                errors++;
                $display("error %s: expected halted %0b, actual %0b", test_label(test_id),
                         exp_halt, halted);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: output %h appeared when none was expected",
                             test_label(test_id), out_data);
                end else begin
                    exp_word = exp_q.pop_front();
                    if (out_data !== exp_word) begin
                        errors++;
                        $display("error %s: expected %h, actual %h", test_label(test_id),
                                 exp_word, out_data);
                    end
                end
            end
            if (halted && !halted_q && exp_q.size() != 0) begin
                errors++;
                $display("%s: core halted with %0d outputs still missing",
                         test_label(test_id), exp_q.size());
            end
            run_q    = run;
            halted_q = halted;
        end
    end

endmodule

/* verif/sap_tb.sv */
`timescale 1ns/10ps

module sap_tb;
    import sap_pkg::*;

    logic  clk;
    logic  arst_n;
    logic  run;
    logic  prog_valid;
    addr_t prog_addr;
    data_t prog_data;
    logic  prog_ready;
    logic  out_valid;
    data_t out_data;
    logic  out_ready;
    logic  halted;
    data_t image [MEM_DEPTH];  // Program staged for the next load
    int    test_id;
    bit    backpressure;       // Random out_ready when set
    int    tb_errors;
    int    total_errors;

    sap_cpu_top sap_cpu_top_i (.*);
    sap_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Out port sink
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            out_ready = !backpressure || ($urandom % 3 == 0);  // Mostly stalled under pressure
        end
    end

    // Poll halted or prog_ready once per cycle up to a limit
    task automatic wait_until(input bit for_halt, input int limit);
        int    n;
        string what;
        n = 0;
        while (!(for_halt ? halted : prog_ready) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!(for_halt ? halted : prog_ready)) begin
            if (for_halt) what = "halted";
            else what = "prog_ready";
            tb_errors++;
            $display("timeout in test %0d, %s not seen within %0d cycles", test_id, what, limit);
        end
    endtask

    // Stop the core, write all 16 bytes, start it and wait for HLT
    task automatic load_and_run(input int limit);
        run = 1'b0;
        @(negedge clk);
        wait_until(1'b0, 20);
        for (int i = 0; i < MEM_DEPTH; i++) begin
            prog_valid = 1'b1;
            prog_addr  = addr_t'(i);
            prog_data  = image[i];
            @(negedge clk);
        end
        prog_valid = 1'b0;
        run        = 1'b1;
        wait_until(1'b1, limit);
    endtask

    task automatic fill_image();
        for (int i = 0; i < MEM_DEPTH; i++) image[i] = {addr_t'(i), ~addr_t'(i)};
    endtask

    task automatic arith_image(input data_t x, input data_t y, input data_t z);
        fill_image();
        image[0]  = {OP_LDA, 4'hD};
        image[1]  = {OP_ADD, 4'hE};
        image[2]  = {OP_OUT, 4'h0};  // x + y
        image[3]  = {OP_SUB, 4'hF};
        image[4]  = {OP_OUT, 4'h0};  // x + y - z
        image[5]  = {OP_HLT, 4'h0};
        image[13] = x;
        image[14] = y;
        image[15] = z;
    endtask

    task automatic store_image(input addr_t v);
        fill_image();
        image[0] = {OP_LDI, v};
        image[1] = {OP_STA, 4'hF};
        image[2] = {OP_LDI, ~v};     // Overwrite A before the read back
        image[3] = {OP_LDA, 4'hF};
        image[4] = {OP_OUT, 4'h0};
        image[5] = {OP_ADD, 4'hF};
        image[6] = {OP_OUT, 4'h0};
        image[7] = {OP_HLT, 4'h0};
    endtask

    // Count down from n with JZ, then one JC not taken and one taken
    task automatic count_image(input data_t n);
        fill_image();
        image[0]  = {OP_LDA, 4'hE};
        image[1]  = {OP_OUT, 4'h0};
        image[2]  = {OP_SUB, 4'hF};
        image[3]  = {OP_JZ,  4'h5};
        image[4]  = {OP_JMP, 4'h1};
        image[5]  = {OP_SUB, 4'hF};  // 0 - 1 clears CF
        image[6]  = {OP_JC,  4'h8};
        image[7]  = {OP_OUT, 4'h0};
        image[8]  = {OP_SUB, 4'hF};  // FF - 1 sets CF
        image[9]  = {OP_JC,  4'hB};
        image[10] = {OP_OUT, 4'h0};  // Skipped
        image[11] = {OP_OUT, 4'h0};
        image[12] = {OP_HLT, 4'h0};
        image[14] = n;
        image[15] = 8'd1;
    endtask

    initial begin
        void'($urandom(91468));
        arst_n       = 1'b0;
        run          = 1'b0;
        prog_valid   = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        backpressure = 1'b0;
        tb_errors    = 0;
        test_id      = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_id = 1;
        repeat (4) begin
            arith_image(data_t'($urandom), data_t'($urandom), data_t'($urandom));
            load_and_run(200);
        end
        test_id = 2;
        repeat (3) begin
            store_image(addr_t'($urandom));
            load_and_run(200);
        end
        test_id = 3;
        repeat (3) begin
            count_image(data_t'($urandom % 5 + 1));
            load_and_run(500);
        end
        test_id      = 4;
        backpressure = 1'b1;
        repeat (4) begin
            arith_image(data_t'($urandom), data_t'($urandom), data_t'($urandom));
            load_and_run(2000);
        end
        backpressure = 1'b0;

        test_id = 5;
        fill_image();
        image[0] = {OP_LDI, 4'h7};
        image[1] = {OP_OUT, 4'h0};
        image[2] = {OP_HLT, 4'h0};
        image[3] = {OP_LDI, 4'h2};  // Must never run
        image[4] = {OP_OUT, 4'h0};
        image[5] = {OP_HLT, 4'h0};
        load_and_run(200);
        repeat (30) @(negedge clk);  // Checker flags any late output
        if (!halted) begin
            tb_errors++;
            $display("halted dropped while run was still high");
        end
        store_image(addr_t'($urandom));
        load_and_run(200);
        run = 1'b0;  // Ends the last run

        repeat (5) @(negedge clk);
        total_errors = checker_i.errors + sap_cpu_top_i.assertions_i.fail_count + tb_errors;
        $display("errors: checker %0d, assertions %0d, testbench %0d", checker_i.errors,
                 sap_cpu_top_i.assertions_i.fail_count, tb_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
rtl/sap_pkg.sv
rtl/sap_ctrl_if.sv
rtl/sap_decode.sv
rtl/sap_execute.sv
rtl/sap_memory.sv
rtl/sap_result.sv
rtl/sap_cpu_top.sv
verif/sap_assertions.sv
verif/sap_checker.sv
verif/sap_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sap_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
